// ==== hw/priv_pkg.sv ====
/*
 * Privilege definitions
 * Encodings of the machine and user modes, the positions of the
 * mstatus fields kept by the controller, and the data and address
 * widths shared across the privilege subsystem.
 */
`default_nettype none

package priv_pkg;

  // Data word and instruction address
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] pc_t;

  // Only U and M are implemented
  // S and N encodings are left out on purpose
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_mode_e;

  // mstatus field positions
  localparam int MSTATUS_MIE_POS  = 3;
  localparam int MSTATUS_MPP_POS  = 11;
  localparam int MSTATUS_MPRV_POS = 17;
  localparam int MSTATUS_TW_POS   = 21;

  // MPP is the only multi-bit field
  localparam int MSTATUS_MPP_W = 2;

endpackage

`default_nettype wire

// ==== hw/insn_pkg.sv ====
/*
 * Instruction definitions
 * Exact encodings of the system instructions, the custom opcode
 * mask and match pairs, the CSR addresses, the exception causes
 * and the instruction classes produced by the decoder.
 */
`default_nettype none

package insn_pkg;

  typedef logic [31:0] insn_t;
  typedef logic [31:0] cause_t;
  typedef logic [11:0] csr_addr_t;

  // One class per system instruction of interest
  typedef enum logic [3:0] {
    CLS_NOP,
    CLS_MRET,
    CLS_URET,
    CLS_WFI,
    CLS_EBREAK,
    CLS_ECALL,
    CLS_CUSTOM,
    CLS_CSRW_MSTATUS,
    CLS_CSRW_MSCRATCH
  } insn_class_e;

  // Exact system encodings
  localparam insn_t INSN_MRET   = 32'h3020_0073;
  localparam insn_t INSN_URET   = 32'h0020_0073;
  localparam insn_t INSN_WFI    = 32'h1050_0073;
  localparam insn_t INSN_EBREAK = 32'h0010_0073;
  localparam insn_t INSN_ECALL  = 32'h0000_0073;

  // Custom opcodes, funct6 and funct3 and opcode are compared
  localparam insn_t CUSTOM0_MASK  = 32'hFC00_707F;
  localparam insn_t CUSTOM0_MATCH = 32'h8C00_0073;
  localparam insn_t CUSTOM1_MASK  = 32'hFC00_707F;
  localparam insn_t CUSTOM1_MATCH = 32'hCC00_0073;

  // csrrw fields
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;
  localparam logic [2:0] F3_CSRRW   = 3'b001;
  localparam csr_addr_t  CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t  CSR_MSCRATCH = 12'h340;

  // mcause values, bit 31 marks an interrupt
  localparam cause_t CAUSE_ILLEGAL    = 32'd2;
  localparam cause_t CAUSE_BREAKPOINT = 32'd3;
  localparam cause_t CAUSE_ECALL_U    = 32'd8;
  localparam cause_t CAUSE_ECALL_M    = 32'd11;
  localparam cause_t CAUSE_IRQ_EXT    = 32'h8000_000B;

endpackage

`default_nettype wire

// ==== hw/insn_classify.sv ====
/*
 * System instruction decoder
 * Turns one instruction word into a single class. Exact system
 * encodings, the custom opcodes and csrrw to mstatus or mscratch
 * are recognized; every other word is a no-op.
 */
`default_nettype none

module insn_classify (
  input  wire insn_pkg::insn_t      insn,
  output insn_pkg::insn_class_e     insn_class
);

  import insn_pkg::*;

  csr_addr_t csr_addr;
  logic      is_csrrw;
  logic      is_custom;

  // CSR address sits in the immediate field
  assign csr_addr = insn[31:20];
  assign is_csrrw = (insn[6:0] == OPC_SYSTEM) && (insn[14:12] == F3_CSRRW);

  // Either custom pattern
  assign is_custom = ((insn & CUSTOM0_MASK) == CUSTOM0_MATCH) ||
                     ((insn & CUSTOM1_MASK) == CUSTOM1_MATCH);

  always_comb begin
    insn_class = CLS_NOP;
    if (insn == INSN_MRET) begin
      insn_class = CLS_MRET;
    end else if (insn == INSN_URET) begin
      insn_class = CLS_URET;
    end else if (insn == INSN_WFI) begin
      insn_class = CLS_WFI;
    end else if (insn == INSN_EBREAK) begin
      insn_class = CLS_EBREAK;
    end else if (insn == INSN_ECALL) begin
      insn_class = CLS_ECALL;
    end else if (is_custom) begin
      insn_class = CLS_CUSTOM;
    end else if (is_csrrw && (csr_addr == CSR_MSTATUS)) begin
      insn_class = CLS_CSRW_MSTATUS;
    end else if (is_csrrw && (csr_addr == CSR_MSCRATCH)) begin
      insn_class = CLS_CSRW_MSCRATCH;
    end
  end

endmodule

`default_nettype wire

// ==== hw/priv_ctrl.sv ====
/*
 * Privilege controller
 * Holds the mode, mstatus, mepc, mscratch and the PC. Each strobe
 * is checked for legality in the current mode, then traps, mret or
 * CSR writes are applied. The retirement appears on the trace one
 * cycle later, together with a refetch when control flow jumps.
 */
`default_nettype none

module priv_ctrl #(
  parameter priv_pkg::pc_t BOOT_ADDR = 32'h0000_0080,
  parameter priv_pkg::pc_t TRAP_VEC  = 32'h0000_0100
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        insn_valid,
  input  wire insn_pkg::insn_t       insn,
  input  wire priv_pkg::xlen_t       insn_wdata,
  input  wire                        irq,
  input  wire insn_pkg::insn_class_e insn_class,
  output logic                       rvfi_valid,
  output priv_pkg::priv_mode_e       rvfi_mode,
  output priv_pkg::pc_t              rvfi_pc,
  output insn_pkg::insn_t            rvfi_insn,
  output logic                       rvfi_trap,
  output logic                       rvfi_intr,
  output insn_pkg::cause_t           rvfi_cause,
  output priv_pkg::xlen_t            rvfi_mstatus_rdata,
  output priv_pkg::xlen_t            rvfi_mstatus_wdata,
  output logic                       rvfi_mscratch_we,
  output logic                       fetch_valid,
  output priv_pkg::pc_t              fetch_addr
);

  import priv_pkg::*;
  import insn_pkg::*;

  // Architectural state
  priv_mode_e mode_q, mode_d;
  xlen_t      mstatus_q, mstatus_d;
  pc_t        mepc_q, mepc_d;
  xlen_t      mscratch_q, mscratch_d;
  pc_t        pc_q, pc_d;

  // Decisions for the instruction at the strobe
  logic                     take_irq;
  logic                     illegal;
  logic                     exc;
  logic                     trap;
  logic                     do_mret;
  logic                     scratch_we;
  cause_t                   cause;
  priv_mode_e               mpp_mode;
  logic [MSTATUS_MPP_W-1:0] wr_mpp;

  // Pending interrupt wins over the instruction
  assign take_irq = irq && mstatus_q[MSTATUS_MIE_POS];
  assign mpp_mode = priv_mode_e'(mstatus_q[MSTATUS_MPP_POS +: MSTATUS_MPP_W]);

  // Legality in the current mode
  always_comb begin
    case (insn_class)
      CLS_URET, CLS_CUSTOM: illegal = 1'b1;
      CLS_MRET, CLS_CSRW_MSTATUS, CLS_CSRW_MSCRATCH: illegal = (mode_q == PRIV_U);
      CLS_WFI: illegal = (mode_q == PRIV_U) && mstatus_q[MSTATUS_TW_POS];
      default: illegal = 1'b0;
    endcase
  end

  // Synchronous exceptions only when not interrupted
  assign exc = !take_irq && (illegal || (insn_class inside {CLS_EBREAK, CLS_ECALL}));
  assign trap = take_irq || exc;
  assign do_mret = !trap && (insn_class == CLS_MRET);
  assign scratch_we = !trap && (insn_class == CLS_CSRW_MSCRATCH);

  // Cause priority: interrupt, illegal, breakpoint, ecall
  always_comb begin
    if (take_irq) begin
      cause = CAUSE_IRQ_EXT;
    end else if (!exc) begin
      cause = '0;
    end else if (illegal) begin
      cause = CAUSE_ILLEGAL;
    end else if (insn_class == CLS_EBREAK) begin
      cause = CAUSE_BREAKPOINT;
    end else if (mode_q == PRIV_U) begin
      cause = CAUSE_ECALL_U;
    end else begin
      cause = CAUSE_ECALL_M;
    end
  end

  // Next state
  always_comb begin
    mode_d     = mode_q;
    mstatus_d  = mstatus_q;
    mepc_d     = mepc_q;
    mscratch_d = mscratch_q;
    pc_d       = pc_q + 32'd4;
    wr_mpp     = insn_wdata[MSTATUS_MPP_POS +: MSTATUS_MPP_W];
    if (trap) begin
      // Save context and enter the handler in M
      mepc_d = pc_q;
      mstatus_d[MSTATUS_MPP_POS +: MSTATUS_MPP_W] = mode_q;
      mstatus_d[MSTATUS_MIE_POS] = 1'b0;
      mode_d = PRIV_M;
      pc_d   = TRAP_VEC;
    end else if (do_mret) begin
      mode_d = mpp_mode;
      mstatus_d[MSTATUS_MPP_POS +: MSTATUS_MPP_W] = PRIV_U;
      // Returning to U drops MPRV
      if (mpp_mode == PRIV_U) begin
        mstatus_d[MSTATUS_MPRV_POS] = 1'b0;
      end
      pc_d = mepc_q;
    end else if (insn_class == CLS_CSRW_MSTATUS) begin
      mstatus_d[MSTATUS_MIE_POS]  = insn_wdata[MSTATUS_MIE_POS];
      mstatus_d[MSTATUS_MPRV_POS] = insn_wdata[MSTATUS_MPRV_POS];
      mstatus_d[MSTATUS_TW_POS]   = insn_wdata[MSTATUS_TW_POS];
      // WARL, unimplemented modes keep the old MPP
      if (wr_mpp inside {PRIV_U, PRIV_M}) begin
        mstatus_d[MSTATUS_MPP_POS +: MSTATUS_MPP_W] = wr_mpp;
      end
    end else if (scratch_we) begin
      mscratch_d = insn_wdata;
    end
  end

  // State and trace strobes
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mode_q      <= PRIV_M;
      mstatus_q   <= '0;
      mepc_q      <= '0;
      mscratch_q  <= '0;
      pc_q        <= BOOT_ADDR;
      rvfi_valid  <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      rvfi_valid  <= insn_valid;
      fetch_valid <= insn_valid && (trap || do_mret);
      if (insn_valid) begin
        mode_q     <= mode_d;
        mstatus_q  <= mstatus_d;
        mepc_q     <= mepc_d;
        mscratch_q <= mscratch_d;
        pc_q       <= pc_d;
      end
    end
  end

  // Trace payload, only meaningful with rvfi_valid
  always_ff @(posedge clk_i) begin
    if (insn_valid) begin
      rvfi_mode          <= mode_q;
      rvfi_pc            <= pc_q;
      rvfi_insn          <= insn;
      rvfi_trap          <= exc;
      rvfi_intr          <= take_irq;
      rvfi_cause         <= cause;
      rvfi_mstatus_rdata <= mstatus_q;
      rvfi_mstatus_wdata <= mstatus_d;
      rvfi_mscratch_we   <= scratch_we;
      fetch_addr         <= pc_d;
    end
  end

  // MPP never takes an unimplemented mode, whatever was written
  a_mpp_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mstatus_q[MSTATUS_MPP_POS +: MSTATUS_MPP_W] inside {PRIV_U, PRIV_M})
    else $error("MPP holds an unimplemented mode");

  // Refetch is only raised alongside a retirement
  a_fetch_with_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid |-> rvfi_valid)
    else $error("fetch without retirement");

endmodule

`default_nettype wire

// ==== hw/umode_check.sv ====
/*
 * User-mode checker
 * Watches the retirement trace and the refetch port. Each user-mode
 * property is a concurrent assertion, and the same conditions feed
 * a saturating violation counter visible at the top level.
 */
`default_nettype none

module umode_check #(
  parameter int CNT_W = 8
) (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       rvfi_valid,
  input  wire priv_pkg::priv_mode_e rvfi_mode,
  input  wire priv_pkg::pc_t        rvfi_pc,
  input  wire insn_pkg::insn_t      rvfi_insn,
  input  wire                       rvfi_trap,
  input  wire                       rvfi_intr,
  input  wire insn_pkg::cause_t     rvfi_cause,
  input  wire priv_pkg::xlen_t      rvfi_mstatus_rdata,
  input  wire priv_pkg::xlen_t      rvfi_mstatus_wdata,
  input  wire                       rvfi_mscratch_we,
  input  wire                       fetch_valid,
  input  wire priv_pkg::pc_t        fetch_addr,
  output logic [CNT_W-1:0]          violation_count
);

  import priv_pkg::*;
  import insn_pkg::*;

  default clocking cb @(posedge clk_i);
  endclocking
  default disable iff (!rst_ni);

  // Fields of the retired instruction
  logic [MSTATUS_MPP_W-1:0] pre_mpp;
  logic [MSTATUS_MPP_W-1:0] post_mpp;
  logic                     is_custom;
  logic                     mret_done;
  logic                     illegal_expected;
  logic                     illegal_trapped;

  // Fetch window since the last retirement
  logic fetched_q;
  pc_t  first_fetch_q;

  // Retirement history
  logic       seen_q;
  logic       trap_pend_q;
  priv_mode_e last_mode_q;

  logic viol_mode;
  logic viol_first;
  logic viol_trap_m;
  logic viol_scratch;
  logic viol_mret_mpp;
  logic viol_mret_mprv;
  logic viol_illegal;
  logic viol_refetch;
  logic violation;

  assign pre_mpp  = rvfi_mstatus_rdata[MSTATUS_MPP_POS +: MSTATUS_MPP_W];
  assign post_mpp = rvfi_mstatus_wdata[MSTATUS_MPP_POS +: MSTATUS_MPP_W];
  assign is_custom = ((rvfi_insn & CUSTOM0_MASK) == CUSTOM0_MATCH) ||
                     ((rvfi_insn & CUSTOM1_MASK) == CUSTOM1_MATCH);

  // mret that actually executed
  assign mret_done = rvfi_valid && (rvfi_insn == INSN_MRET) && !rvfi_trap && !rvfi_intr;

  // Interrupted instructions never execute, so no illegal trap is owed
  assign illegal_expected = rvfi_valid && !rvfi_intr &&
    (((rvfi_mode == PRIV_U) && (rvfi_insn == INSN_WFI) &&
      rvfi_mstatus_rdata[MSTATUS_TW_POS]) ||
     (rvfi_insn == INSN_URET) || is_custom);
  assign illegal_trapped = rvfi_trap && (rvfi_cause == CAUSE_ILLEGAL);

  // Retirement opens a new window, a fetch in the same cycle belongs to it
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      fetched_q <= 1'b0;
    end else if (fetch_valid) begin
      fetched_q <= 1'b1;
    end else if (rvfi_valid) begin
      fetched_q <= 1'b0;
    end
  end

  // Address of the first fetch in the window
  always_ff @(posedge clk_i) begin
    if (fetch_valid && (rvfi_valid || !fetched_q)) begin
      first_fetch_q <= fetch_addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      seen_q      <= 1'b0;
      trap_pend_q <= 1'b0;
      last_mode_q <= PRIV_M;
    end else if (rvfi_valid) begin
      seen_q      <= 1'b1;
      trap_pend_q <= rvfi_trap || rvfi_intr;
      last_mode_q <= rvfi_mode;
    end
  end

  // Same conditions as the properties below
  assign viol_mode      = rvfi_valid && !(rvfi_mode inside {PRIV_U, PRIV_M});
  assign viol_first     = rvfi_valid && !seen_q && (rvfi_mode != PRIV_M);
  assign viol_trap_m    = rvfi_valid && trap_pend_q && (rvfi_mode != PRIV_M);
  assign viol_scratch   = rvfi_valid && (rvfi_mode == PRIV_U) && rvfi_mscratch_we;
  assign viol_mret_mpp  = mret_done && (post_mpp != PRIV_U);
  assign viol_mret_mprv = mret_done && (pre_mpp == PRIV_U) &&
                          rvfi_mstatus_wdata[MSTATUS_MPRV_POS];
  assign viol_illegal   = illegal_expected && !illegal_trapped;
  assign viol_refetch   = rvfi_valid && seen_q && (rvfi_mode != last_mode_q) &&
                          !(fetched_q && (first_fetch_q == rvfi_pc));

  assign violation = viol_mode || viol_first || viol_trap_m || viol_scratch ||
                     viol_mret_mpp || viol_mret_mprv || viol_illegal || viol_refetch;

  // Saturating count, one step per offending retirement
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      violation_count <= '0;
    end else if (violation && (violation_count != {CNT_W{1'b1}})) begin
      violation_count <= violation_count + 1'b1;
    end
  end

  a_mode_legal: assert property (rvfi_valid |-> rvfi_mode inside {PRIV_U, PRIV_M})
    else $error("retirement in an unimplemented mode");

  a_first_mode: assert property (rvfi_valid && !seen_q |-> rvfi_mode == PRIV_M)
    else $error("first retirement after reset not in M");

  // Handler runs in M after any trap or interrupt
  a_trap_to_m: assert property (
    rvfi_valid && (rvfi_trap || rvfi_intr) |=> (rvfi_valid [->1]) ##0 (rvfi_mode == PRIV_M))
    else $error("trap not handled in M");

  a_mscratch_u: assert property (rvfi_valid && (rvfi_mode == PRIV_U) |-> !rvfi_mscratch_we)
    else $error("mscratch written in U");

  a_mret_mpp: assert property (mret_done |-> post_mpp == PRIV_U)
    else $error("mret left MPP other than U");

  a_mret_mprv: assert property (
    mret_done && (pre_mpp == PRIV_U) |-> !rvfi_mstatus_wdata[MSTATUS_MPRV_POS])
    else $error("mret to U kept MPRV set");

  a_illegal: assert property (
    illegal_expected |-> rvfi_trap && (rvfi_cause == CAUSE_ILLEGAL))
    else $error("illegal instruction retired without trap");

  // A mode change needs a fetch at the new PC since the previous retirement
  property p_refetch;
    priv_mode_e m0;
    (rvfi_valid, m0 = rvfi_mode) ##1 (rvfi_valid [->1]) ##0 (rvfi_mode != m0)
    |-> fetched_q && (first_fetch_q == rvfi_pc);
  endproperty

  a_refetch: assert property (p_refetch)
    else $error("mode change without refetch");

endmodule

`default_nettype wire

// ==== hw/priv_top.sv ====
/*
 * Privilege subsystem top level
 * Decoder, privilege controller and user-mode checker, with the
 * boot address, trap vector and counter width passed down.
 */
`default_nettype none

module priv_top #(
  parameter priv_pkg::pc_t BOOT_ADDR = 32'h0000_0080,
  parameter priv_pkg::pc_t TRAP_VEC  = 32'h0000_0100,
  parameter int            CNT_W     = 8
) (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire                   insn_valid,
  input  wire insn_pkg::insn_t  insn,
  input  wire priv_pkg::xlen_t  insn_wdata,
  input  wire                   irq,
  output logic                  rvfi_valid,
  output priv_pkg::priv_mode_e  rvfi_mode,
  output priv_pkg::pc_t         rvfi_pc,
  output insn_pkg::insn_t       rvfi_insn,
  output logic                  rvfi_trap,
  output logic                  rvfi_intr,
  output insn_pkg::cause_t      rvfi_cause,
  output priv_pkg::xlen_t       rvfi_mstatus_rdata,
  output priv_pkg::xlen_t       rvfi_mstatus_wdata,
  output logic                  rvfi_mscratch_we,
  output logic                  fetch_valid,
  output priv_pkg::pc_t         fetch_addr,
  output logic [CNT_W-1:0]      violation_count
);

  import insn_pkg::*;

  // Decoded class of the strobed instruction
  insn_class_e insn_class;

  insn_classify u_insn_classify (
    .insn       (insn),
    .insn_class (insn_class)
  );

  priv_ctrl #(
    .BOOT_ADDR (BOOT_ADDR),
    .TRAP_VEC  (TRAP_VEC)
  ) u_priv_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .insn_valid         (insn_valid),
    .insn               (insn),
    .insn_wdata         (insn_wdata),
    .irq                (irq),
    .insn_class         (insn_class),
    .rvfi_valid         (rvfi_valid),
    .rvfi_mode          (rvfi_mode),
    .rvfi_pc            (rvfi_pc),
    .rvfi_insn          (rvfi_insn),
    .rvfi_trap          (rvfi_trap),
    .rvfi_intr          (rvfi_intr),
    .rvfi_cause         (rvfi_cause),
    .rvfi_mstatus_rdata (rvfi_mstatus_rdata),
    .rvfi_mstatus_wdata (rvfi_mstatus_wdata),
    .rvfi_mscratch_we   (rvfi_mscratch_we),
    .fetch_valid        (fetch_valid),
    .fetch_addr         (fetch_addr)
  );

  // Checker sees exactly what leaves the controller
  umode_check #(
    .CNT_W (CNT_W)
  ) u_umode_check (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .rvfi_valid         (rvfi_valid),
    .rvfi_mode          (rvfi_mode),
    .rvfi_pc            (rvfi_pc),
    .rvfi_insn          (rvfi_insn),
    .rvfi_trap          (rvfi_trap),
    .rvfi_intr          (rvfi_intr),
    .rvfi_cause         (rvfi_cause),
    .rvfi_mstatus_rdata (rvfi_mstatus_rdata),
    .rvfi_mstatus_wdata (rvfi_mstatus_wdata),
    .rvfi_mscratch_we   (rvfi_mscratch_we),
    .fetch_valid        (fetch_valid),
    .fetch_addr         (fetch_addr),
    .violation_count    (violation_count)
  );

endmodule

`default_nettype wire

// ==== dv/priv_tb.sv ====
/*
 * Privilege subsystem testbench
 * Sends a seeded random mix of system instructions with random gaps
 * and interrupts. A model of the M/U privilege rules predicts every
 * retirement and refetch, and the checker count must stay at zero.
 */
`default_nettype none

module priv_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import priv_pkg::*;
  import insn_pkg::*;

  localparam pc_t BOOT_ADDR = 32'h0000_0200;
  localparam pc_t TRAP_VEC  = 32'h0000_0400;
  localparam int  CNT_W     = 8;
  localparam int  N_INSN    = 400;
  localparam int  RST_CYC   = 8;
  localparam int  TIMEOUT_CYC = 4 * N_INSN + RST_CYC;

  // Instruction kinds of the stimulus pool
  localparam int K_NOP     = 0;
  localparam int K_MRET    = 1;
  localparam int K_URET    = 2;
  localparam int K_WFI     = 3;
  localparam int K_EBREAK  = 4;
  localparam int K_ECALL   = 5;
  localparam int K_CUSTOM  = 6;
  localparam int K_CSR_MS  = 7;
  localparam int K_CSR_SCR = 8;

  // One predicted retirement
  typedef struct packed {
    logic [1:0] mode;
    pc_t        pc;
    insn_t      insn;
    logic       trap;
    logic       intr;
    cause_t     cause;
    xlen_t      ms_rd;
    xlen_t      ms_wr;
    logic       scr_we;
    logic       fetch;
    pc_t        fetch_addr;
  } retire_t;

  logic clk_i, rst_ni, insn_valid, irq;
  insn_t insn;
  xlen_t insn_wdata;
  logic rvfi_valid, rvfi_trap, rvfi_intr, rvfi_mscratch_we, fetch_valid;
  logic [1:0] rvfi_mode;
  pc_t rvfi_pc, fetch_addr;
  insn_t rvfi_insn;
  cause_t rvfi_cause;
  xlen_t rvfi_mstatus_rdata, rvfi_mstatus_wdata;
  logic [CNT_W-1:0] violation_count;

  retire_t exp_q[$];
  integer  seed;
  int      n_errors, n_retired, n_sent, cycle_cnt;
  logic    strobe_seen;

  // Model state
  logic [1:0] m_mode;
  xlen_t      m_mstatus;
  pc_t        m_pc, m_mepc;

  priv_top #(
    .BOOT_ADDR (BOOT_ADDR),
    .TRAP_VEC  (TRAP_VEC),
    .CNT_W     (CNT_W)
  ) u_priv_top (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .insn_valid         (insn_valid),
    .insn               (insn),
    .insn_wdata         (insn_wdata),
    .irq                (irq),
    .rvfi_valid         (rvfi_valid),
    .rvfi_mode          (rvfi_mode),
    .rvfi_pc            (rvfi_pc),
    .rvfi_insn          (rvfi_insn),
    .rvfi_trap          (rvfi_trap),
    .rvfi_intr          (rvfi_intr),
    .rvfi_cause         (rvfi_cause),
    .rvfi_mstatus_rdata (rvfi_mstatus_rdata),
    .rvfi_mstatus_wdata (rvfi_mstatus_wdata),
    .rvfi_mscratch_we   (rvfi_mscratch_we),
    .fetch_valid        (fetch_valid),
    .fetch_addr         (fetch_addr),
    .violation_count    (violation_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // Privilege rules applied to one strobed instruction
  task automatic predict(input int kind, input insn_t word, input xlen_t wdata,
                         input logic irq_lvl);
    retire_t    r;
    logic       illegal;
    logic [1:0] next_mode;
    logic [1:0] wr_mpp;
    illegal = 1'b0;
    case (kind)
      K_URET, K_CUSTOM: illegal = 1'b1;
      K_MRET, K_CSR_MS, K_CSR_SCR: illegal = (m_mode == 2'b00);
      K_WFI: illegal = (m_mode == 2'b00) && m_mstatus[21];
      default: illegal = 1'b0;
    endcase
    r = '0;
    r.mode  = m_mode;
    r.pc    = m_pc;
    r.insn  = word;
    r.ms_rd = m_mstatus;
    r.intr  = irq_lvl && m_mstatus[3];
    r.trap  = !r.intr && (illegal || kind == K_EBREAK || kind == K_ECALL);
    if (r.intr) r.cause = 32'h8000_000B;
    else if (illegal) r.cause = 32'd2;
    else if (kind == K_EBREAK) r.cause = 32'd3;
    else if (kind == K_ECALL) r.cause = (m_mode == 2'b00) ? 32'd8 : 32'd11;
    next_mode  = m_mode;
    r.ms_wr    = m_mstatus;
    r.fetch_addr = m_pc + 32'd4;
    if (r.intr || r.trap) begin
      m_mepc = m_pc;
      r.ms_wr[12:11] = m_mode;
      r.ms_wr[3] = 1'b0;
      next_mode = 2'b11;
      r.fetch = 1'b1;
      r.fetch_addr = TRAP_VEC;
    end else if (kind == K_MRET) begin
      next_mode = m_mstatus[12:11];
      r.ms_wr[12:11] = 2'b00;
      if (next_mode == 2'b00) r.ms_wr[17] = 1'b0;
      r.fetch = 1'b1;
      r.fetch_addr = m_mepc;
    end else if (kind == K_CSR_MS) begin
      r.ms_wr[3]  = wdata[3];
      r.ms_wr[17] = wdata[17];
      r.ms_wr[21] = wdata[21];
      // MPP values 1 and 2 are not implemented and are dropped
      wr_mpp = wdata[12:11];
      if (wr_mpp == 2'b00 || wr_mpp == 2'b11) r.ms_wr[12:11] = wr_mpp;
    end else if (kind == K_CSR_SCR) begin
      r.scr_we = 1'b1;
    end
    m_mode    = next_mode;
    m_mstatus = r.ms_wr;
    m_pc      = r.fetch_addr;
    exp_q.push_back(r);
  endtask

  // Trace sampled mid-cycle, one cycle after each strobe
  always @(negedge clk_i) begin : trace_monitor
    retire_t e;
    if (rst_ni) begin
      check_value("rvfi_valid", rvfi_valid, strobe_seen);
      if (rvfi_valid) n_retired++;
      if (strobe_seen) begin
        e = exp_q.pop_front();
        check_value("rvfi_mode", rvfi_mode, e.mode);
        check_value("rvfi_pc", rvfi_pc, e.pc);
        check_value("rvfi_insn", rvfi_insn, e.insn);
        check_value("rvfi_trap", rvfi_trap, e.trap);
        check_value("rvfi_intr", rvfi_intr, e.intr);
        if (e.trap || e.intr) check_value("rvfi_cause", rvfi_cause, e.cause);
        check_value("rvfi_mstatus_rdata", rvfi_mstatus_rdata, e.ms_rd);
        check_value("rvfi_mstatus_wdata", rvfi_mstatus_wdata, e.ms_wr);
        check_value("rvfi_mscratch_we", rvfi_mscratch_we, e.scr_we);
        check_value("fetch_valid", fetch_valid, e.fetch);
        if (e.fetch) check_value("fetch_addr", fetch_addr, e.fetch_addr);
      end else begin
        check_value("fetch_valid", fetch_valid, 1'b0);
      end
      check_value("violation_count", violation_count, '0);
    end
    strobe_seen = insn_valid;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions sent",
               cycle_cnt, n_sent, N_INSN);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin : stimulus
    int    kind;
    int    pick;
    int    gap;
    insn_t word;
    xlen_t wdata;
    logic  irq_lvl;
    seed = 19;
    n_errors = 0;
    n_retired = 0;
    n_sent = 0;
    cycle_cnt = 0;
    strobe_seen = 1'b0;
    rst_ni = 1'b0;
    insn_valid = 1'b0;
    insn = '0;
    insn_wdata = '0;
    irq = 1'b0;
    m_mode = 2'b11;
    m_mstatus = '0;
    m_mepc = '0;
    m_pc = BOOT_ADDR;
    repeat (RST_CYC) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < N_INSN; i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk_i);
        insn_valid <= 1'b0;
        irq <= ($unsigned($random(seed)) % 6) == 0;
      end
      @(posedge clk_i);
      pick  = $unsigned($random(seed)) % 16;
      wdata = $random(seed);
      word  = $random(seed);
      irq_lvl = ($unsigned($random(seed)) % 6) == 0;
      // Weighted pool, mret is frequent so U mode gets visited
      case (pick)
        0, 1, 2, 3: begin
          kind = K_NOP;
          word = 32'h0000_0013;
        end
        4, 5, 6: begin
          kind = K_MRET;
          word = 32'h3020_0073;
        end
        7: begin
          kind = K_URET;
          word = 32'h0020_0073;
        end
        8: begin
          kind = K_WFI;
          word = 32'h1050_0073;
        end
        9: begin
          kind = K_EBREAK;
          word = 32'h0010_0073;
        end
        10: begin
          kind = K_ECALL;
          word = 32'h0000_0073;
        end
        11: begin
          kind = K_CUSTOM;
          word = 32'h8C00_0073 | (word & 32'h03FF_8F80);
        end
        12: begin
          kind = K_CUSTOM;
          word = 32'hCC00_0073 | (word & 32'h03FF_8F80);
        end
        13, 14: begin
          kind = K_CSR_MS;
          word = 32'h3000_1073 | (word & 32'h000F_8F80);
        end
        default: begin
          kind = K_CSR_SCR;
          word = 32'h3400_1073 | (word & 32'h000F_8F80);
        end
      endcase
      insn_valid <= 1'b1;
      insn       <= word;
      insn_wdata <= wdata;
      irq        <= irq_lvl;
      predict(kind, word, wdata, irq_lvl);
      n_sent++;
    end
    @(posedge clk_i);
    insn_valid <= 1'b0;
    irq <= 1'b0;
    // Drain the model, then leave time for the checker counter
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    check_value("retired_count", n_retired, N_INSN);
    $display("Retirements checked: %0d, errors: %0d", n_retired, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/priv_pkg.sv
hw/insn_pkg.sv
hw/insn_classify.sv
hw/priv_ctrl.sv
hw/umode_check.sv
hw/priv_top.sv
dv/priv_tb.sv
